/* source/hand_link_defs.svh */
`ifndef HAND_LINK_DEFS_SVH
`define HAND_LINK_DEFS_SVH

// system clock rate in hz
`define HAND_LINK_CLK_HZ 65000000

// serial line rate between the camera boards
`define HAND_LINK_BAUD 115200

// clock cycles per serial bit, 564 at 65 mhz
`define HAND_LINK_CLKS_PER_BIT (`HAND_LINK_CLK_HZ / `HAND_LINK_BAUD)

// frame sync value and lengths in bytes
`define HAND_LINK_SYNC_BYTE 8'hFF
`define HAND_LINK_SYNC_LEN 3
`define HAND_LINK_PAYLOAD_LEN 6

// width of the display refresh counter
// top three bits pick the active digit
`define HAND_LINK_REFRESH_BITS 16

`endif

/* source/hand_link_pkg.sv */
package hand_link_pkg;

  // one camera coordinate, 12 bits
  typedef logic [11:0] coord_t;

  // serial receiver states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    START = 2'd1,
    DATA  = 2'd2,
    STOP  = 2'd3
  } rx_state_e;

  // frame parser states
  // hunt looks for the sync run, payload collects the six bytes
  typedef enum logic {
    HUNT    = 1'b0,
    PAYLOAD = 1'b1
  } parse_state_e;

endpackage

/* source/uart_rx.sv */
`timescale 1ns/100ps
`include "hand_link_defs.svh"

module uart_rx (
  input  logic       clk_65mhz,
  input  logic       sys_rst,
  input  logic       rxd,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  localparam int CPB = `HAND_LINK_CLKS_PER_BIT;
  localparam int TW  = $clog2(CPB);
  // last count of a full bit and of half a bit
  localparam logic [TW-1:0] BIT_LAST  = TW'(CPB - 1);
  localparam logic [TW-1:0] HALF_LAST = TW'(CPB / 2 - 1);

  hand_link_pkg::rx_state_e state;

  logic          rxd_meta;
  logic          rxd_sync;
  logic [TW-1:0] timer;
  logic [2:0]    bit_idx;
  logic [7:0]    shift_reg;
  // set while waiting out the rest of a bad stop bit
  logic          stop_err;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // shift register and output byte carry no reset
  always_ff @(posedge clk_65mhz) begin
    if (state == hand_link_pkg::DATA && timer == BIT_LAST) begin
      // lsb arrives first, shift in from the top
      shift_reg <= {rxd_sync, shift_reg[7:1]};
    end
    if (state == hand_link_pkg::STOP && !stop_err && timer == BIT_LAST && rxd_sync) begin
      rx_byte <= shift_reg;
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state    <= hand_link_pkg::IDLE;
      timer    <= '0;
      bit_idx  <= '0;
      stop_err <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        hand_link_pkg::IDLE: begin
          timer   <= '0;
          bit_idx <= '0;
          // low line means a possible start bit
          if (!rxd_sync) begin
            state <= hand_link_pkg::START;
          end
        end
        hand_link_pkg::START: begin
          if (timer == HALF_LAST) begin
            timer <= '0;
            // glitch if the line is back high at mid start bit
            state <= rxd_sync ? hand_link_pkg::IDLE : hand_link_pkg::DATA;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        hand_link_pkg::DATA: begin
          if (timer == BIT_LAST) begin
            timer   <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= hand_link_pkg::STOP;
            end
          end else begin
            timer <= timer + 1'b1;
          end
        end
        hand_link_pkg::STOP: begin
          if (stop_err) begin
            // hold until the stop bit would have ended
            if (timer == HALF_LAST) begin
              stop_err <= 1'b0;
              state    <= hand_link_pkg::IDLE;
            end else begin
              timer <= timer + 1'b1;
            end
          end else if (timer == BIT_LAST) begin
            timer <= '0;
            if (rxd_sync) begin
              rx_valid <= 1'b1;
              state    <= hand_link_pkg::IDLE;
            end else begin
              // framing error, byte is dropped
              stop_err <= 1'b1;
            end
          end else begin
            timer <= timer + 1'b1;
          end
        end
        default: state <= hand_link_pkg::IDLE;
      endcase
    end
  end

endmodule

/* source/hand_frame_parser.sv */
`timescale 1ns/100ps
`include "hand_link_defs.svh"

module hand_frame_parser (
  input  logic                  clk_65mhz,
  input  logic                  sys_rst,
  input  logic [7:0]            rx_byte,
  input  logic                  rx_valid,
  output hand_link_pkg::coord_t hand_z_bottom,
  output hand_link_pkg::coord_t remote_y_bottom,
  output hand_link_pkg::coord_t hand_z_top,
  output hand_link_pkg::coord_t remote_y_top,
  output logic                  frame_valid
);

  localparam int SYNC_LEN = `HAND_LINK_SYNC_LEN;
  localparam int PAY_LEN  = `HAND_LINK_PAYLOAD_LEN;
  localparam int SW       = $clog2(SYNC_LEN);
  localparam int BW       = $clog2(PAY_LEN);
  localparam logic [SW-1:0] SYNC_LAST = SW'(SYNC_LEN - 1);
  localparam logic [BW-1:0] BYTE_LAST = BW'(PAY_LEN - 1);

  hand_link_pkg::parse_state_e state;

  logic [SW-1:0] sync_cnt;
  logic [BW-1:0] byte_cnt;
  // first five payload bytes, the sixth is taken straight from rx_byte
  logic [7:0]    stage [PAY_LEN-1];

  // staging buffer has no reset
  always_ff @(posedge clk_65mhz) begin
    if (state == hand_link_pkg::PAYLOAD && rx_valid && byte_cnt != BYTE_LAST) begin
      stage[byte_cnt] <= rx_byte;
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state           <= hand_link_pkg::HUNT;
      sync_cnt        <= '0;
      byte_cnt        <= '0;
      hand_z_bottom   <= '0;
      remote_y_bottom <= '0;
      hand_z_top      <= '0;
      remote_y_top    <= '0;
      frame_valid     <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      if (rx_valid) begin
        case (state)
          hand_link_pkg::HUNT: begin
            if (rx_byte == `HAND_LINK_SYNC_BYTE) begin
              if (sync_cnt == SYNC_LAST) begin
                sync_cnt <= '0;
                byte_cnt <= '0;
                state    <= hand_link_pkg::PAYLOAD;
              end else begin
                sync_cnt <= sync_cnt + 1'b1;
              end
            end else begin
              // broken sync run, start counting again
              sync_cnt <= '0;
            end
          end
          hand_link_pkg::PAYLOAD: begin
            // payload bytes are taken whatever their value, 0xff included
            if (byte_cnt == BYTE_LAST) begin
              // x goes out as depth, the second camera sees the side view
              hand_z_bottom   <= {stage[0], stage[1][7:4]};
              remote_y_bottom <= {stage[1][3:0], stage[2]};
              hand_z_top      <= {stage[3], stage[4][7:4]};
              remote_y_top    <= {stage[4][3:0], rx_byte};
              frame_valid     <= 1'b1;
              byte_cnt        <= '0;
              state           <= hand_link_pkg::HUNT;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
          default: state <= hand_link_pkg::HUNT;
        endcase
      end
    end
  end

endmodule

/* source/seven_segment_controller.sv */
`timescale 1ns/100ps
`include "hand_link_defs.svh"

module seven_segment_controller (
  input  logic        clk_65mhz,
  input  logic        sys_rst,
  input  logic [31:0] val,
  output logic [7:0]  an,
  output logic [6:0]  cat
);

  localparam int RB = `HAND_LINK_REFRESH_BITS;

  logic [RB-1:0] refresh_cnt;
  logic [2:0]    digit;
  logic [3:0]    nibble;
  // active-high glyph, bit 0 is segment a
  logic [6:0]    glyph;

  // top bits of the free-running counter pick the digit
  assign digit  = refresh_cnt[RB-1 -: 3];
  assign nibble = val[digit*4 +: 4];

  // hex glyph table, segments g down to a
  always_comb begin
    case (nibble)
      4'h0: glyph = 7'b0111111;
      4'h1: glyph = 7'b0000110;
      4'h2: glyph = 7'b1011011;
      4'h3: glyph = 7'b1001111;
      4'h4: glyph = 7'b1100110;
      4'h5: glyph = 7'b1101101;
      4'h6: glyph = 7'b1111101;
      4'h7: glyph = 7'b0000111;
      4'h8: glyph = 7'b1111111;
      4'h9: glyph = 7'b1101111;
      4'hA: glyph = 7'b1110111;
      4'hB: glyph = 7'b1111100;
      4'hC: glyph = 7'b0111001;
      4'hD: glyph = 7'b1011110;
      4'hE: glyph = 7'b1111001;
      default: glyph = 7'b1110001;
    endcase
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      refresh_cnt <= '0;
      // all digits dark, all segments off
      an          <= 8'hFF;
      cat         <= 7'h7F;
    end else begin
      refresh_cnt <= refresh_cnt + 1'b1;
      // one anode low at a time
      an          <= ~(8'b1 << digit);
      // segments are active low
      cat         <= ~glyph;
    end
  end

endmodule

/* source/hand_link_top.sv */
`timescale 1ns/100ps

module hand_link_top (
  input  logic                  clk_65mhz,
  input  logic                  sys_rst,
  input  logic                  rxd,
  output hand_link_pkg::coord_t hand_z_bottom,
  output hand_link_pkg::coord_t remote_y_bottom,
  output hand_link_pkg::coord_t hand_z_top,
  output hand_link_pkg::coord_t remote_y_top,
  output logic                  frame_valid,
  output logic [7:0]            an,
  output logic [6:0]            cat
);

  logic [7:0]  rx_byte;
  logic        rx_valid;
  logic [31:0] disp_word;

  // serial bytes from the second camera board
  uart_rx u_rx (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .rxd       (rxd),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid)
  );

  // sync hunting and coordinate unpacking
  hand_frame_parser u_parser (
    .clk_65mhz       (clk_65mhz),
    .sys_rst         (sys_rst),
    .rx_byte         (rx_byte),
    .rx_valid        (rx_valid),
    .hand_z_bottom   (hand_z_bottom),
    .remote_y_bottom (remote_y_bottom),
    .hand_z_top      (hand_z_top),
    .remote_y_top    (remote_y_top),
    .frame_valid     (frame_valid)
  );

  // bottom point on the display, digits 7 and 3 blank as zero
  assign disp_word = {4'h0, hand_z_bottom, 4'h0, remote_y_bottom};

  seven_segment_controller u_display (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .val       (disp_word),
    .an        (an),
    .cat       (cat)
  );

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk
);

  // free-running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

/* bench/hand_link_tb.sv */
`timescale 1ns/100ps
`include "hand_link_defs.svh"

module hand_link_tb;

  localparam int CPB         = `HAND_LINK_CLKS_PER_BIT;
  localparam int FRAME_BYTES = `HAND_LINK_SYNC_LEN + `HAND_LINK_PAYLOAD_LEN;
  localparam int NUM_RANDOM  = 20;
  // random frames, six garbage bytes, one clean frame, three frames around the bad stop bit
  localparam int TOTAL_BYTES = NUM_RANDOM * FRAME_BYTES + 6 + 4 * FRAME_BYTES;
  // one full pass over all eight digits
  localparam int DISP_WAIT   = 1 << `HAND_LINK_REFRESH_BITS;
  localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 12 * CPB + 2 * DISP_WAIT + 50000;

  logic                  clk_65mhz;
  logic                  sys_rst;
  logic                  rxd;
  hand_link_pkg::coord_t hand_z_bottom;
  hand_link_pkg::coord_t remote_y_bottom;
  hand_link_pkg::coord_t hand_z_top;
  hand_link_pkg::coord_t remote_y_top;
  logic                  frame_valid;
  logic [7:0]            an;
  logic [6:0]            cat;

  // expected frames in order, {zb, yb, zt, yt}
  logic [47:0]           exp_q [$];
  // model outputs after the last frame that was checked
  hand_link_pkg::coord_t cur_zb, cur_yb, cur_zt, cur_yt;
  logic [31:0]           lcg_state;

  clock_gen #(.PERIOD_NS(8.0)) u_clk (.clk(clk_65mhz));

  hand_link_top uut (
    .clk_65mhz       (clk_65mhz),
    .sys_rst         (sys_rst),
    .rxd             (rxd),
    .hand_z_bottom   (hand_z_bottom),
    .remote_y_bottom (remote_y_bottom),
    .hand_z_top      (hand_z_top),
    .remote_y_top    (remote_y_top),
    .frame_valid     (frame_valid),
    .an              (an),
    .cat             (cat)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // middle bits of the lcg word, the low bits repeat too quickly
  function automatic logic [11:0] rand_coord();
    logic [31:0] r;
    r = lcg_next();
    return r[27:16];
  endfunction

  // six payload bytes, first byte in the top bits
  function automatic logic [47:0] pack_payload(input logic [11:0] zb, input logic [11:0] yb,
                                               input logic [11:0] zt, input logic [11:0] yt);
    logic [7:0] b [6];
    b[0] = zb[11:4];
    b[1] = {zb[3:0], yb[11:8]};
    b[2] = yb[7:0];
    b[3] = zt[11:4];
    b[4] = {zt[3:0], yt[11:8]};
    b[5] = yt[7:0];
    return {b[0], b[1], b[2], b[3], b[4], b[5]};
  endfunction

  // reassemble {zb, yb, zt, yt} from six payload bytes
  function automatic logic [47:0] unpack_payload(input logic [47:0] bytes);
    logic [7:0]  b [6];
    logic [11:0] zb, yb, zt, yt;
    for (int k = 0; k < 6; k++) begin
      b[k] = bytes[47 - 8 * k -: 8];
    end
    zb = {b[0], b[1][7:4]};
    yb = {b[1][3:0], b[2]};
    zt = {b[3], b[4][7:4]};
    yt = {b[4][3:0], b[5]};
    return {zb, yb, zt, yt};
  endfunction

  // active-high segments, bit 0 is a
  function automatic logic [6:0] hex_glyph(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h3F;
      4'h1: return 7'h06;
      4'h2: return 7'h5B;
      4'h3: return 7'h4F;
      4'h4: return 7'h66;
      4'h5: return 7'h6D;
      4'h6: return 7'h7D;
      4'h7: return 7'h07;
      4'h8: return 7'h7F;
      4'h9: return 7'h6F;
      4'hA: return 7'h77;
      4'hB: return 7'h7C;
      4'hC: return 7'h39;
      4'hD: return 7'h5E;
      4'hE: return 7'h79;
      default: return 7'h71;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("ERR %s expected %h actual %h", name, exp_val, act_val);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // one bit on the line, always called on a falling edge
  task automatic drive_bit(input logic value);
    rxd = value;
    repeat (CPB) @(negedge clk_65mhz);
  endtask

  task automatic send_byte(input logic [7:0] b, input bit bad_stop);
    drive_bit(1'b0);
    // lsb first
    for (int k = 0; k < 8; k++) begin
      drive_bit(b[k]);
    end
    if (bad_stop) begin
      drive_bit(1'b0);
      // idle bit so the next start edge is clean
      drive_bit(1'b1);
    end else begin
      drive_bit(1'b1);
    end
  endtask

  // bad_idx picks a payload byte sent with a low stop bit, -1 for none
  task automatic send_frame(input logic [47:0] payload, input int bad_idx);
    for (int k = 0; k < `HAND_LINK_SYNC_LEN; k++) begin
      send_byte(`HAND_LINK_SYNC_BYTE, 1'b0);
    end
    for (int k = 0; k < `HAND_LINK_PAYLOAD_LEN; k++) begin
      send_byte(payload[47 - 8 * k -: 8], k == bad_idx);
    end
  endtask

  task automatic wait_frames_done();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      if (n >= 2 * CPB) begin
        abort_run("expected frame_valid pulse never arrived");
      end
      @(negedge clk_65mhz);
      n++;
    end
  endtask

  // outputs must still hold the last checked frame
  task automatic check_steady(input string name);
    check_value({name, " hand_z_bottom"}, cur_zb, hand_z_bottom);
    check_value({name, " remote_y_bottom"}, cur_yb, remote_y_bottom);
    check_value({name, " hand_z_top"}, cur_zt, hand_z_top);
    check_value({name, " remote_y_top"}, cur_yt, remote_y_top);
  endtask

  // compare every frame_valid against the next expected frame
  always @(negedge clk_65mhz) begin : frame_monitor
    logic [47:0] e;
    if (!sys_rst && frame_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run("frame_valid pulsed when no frame was expected");
      end
      e = exp_q.pop_front();
      check_value("frame hand_z_bottom", e[47:36], hand_z_bottom);
      check_value("frame remote_y_bottom", e[35:24], remote_y_bottom);
      check_value("frame hand_z_top", e[23:12], hand_z_top);
      check_value("frame remote_y_top", e[11:0], remote_y_top);
      {cur_zb, cur_yb, cur_zt, cur_yt} = e;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_65mhz);
    abort_run("timeout, the run took longer than the watchdog allows");
  end

  initial begin : stimulus
    logic [11:0] zb, yb, zt, yt;
    logic [47:0] pay;
    logic [47:0] acc;
    logic [31:0] word;
    int          n;
    lcg_state = 32'd50;
    sys_rst   = 1'b1;
    rxd       = 1'b1;
    {cur_zb, cur_yb, cur_zt, cur_yt} = '0;
    repeat (10) @(negedge clk_65mhz);
    // reset values, checked while reset is still held
    check_steady("reset");
    check_value("reset frame_valid", 32'd0, frame_valid);
    check_value("reset cat", 32'h7F, cat);
    check_value("reset an", 32'hFF, an);
    sys_rst = 1'b0;
    repeat (20) @(negedge clk_65mhz);

    // random frames, a few forced to carry 0xff payload bytes
    for (int i = 0; i < NUM_RANDOM; i++) begin
      zb = rand_coord();
      yb = rand_coord();
      zt = rand_coord();
      yt = rand_coord();
      if (i == 3) begin
        zb = 12'hFFF;
        yb = 12'hFFF;
      end
      if (i == 7) begin
        zt = 12'hFFF;
        yt = 12'hF00;
      end
      exp_q.push_back({zb, yb, zt, yt});
      send_frame(pack_payload(zb, yb, zt, yt), -1);
      wait_frames_done();
    end

    // garbage, then a sync run cut short
    send_byte(8'h12, 1'b0);
    send_byte(8'h34, 1'b0);
    send_byte(8'hA5, 1'b0);
    send_byte(8'hFF, 1'b0);
    send_byte(8'hFF, 1'b0);
    send_byte(8'h5A, 1'b0);
    check_steady("garbage");
    zb = rand_coord();
    yb = rand_coord();
    zt = rand_coord();
    yt = rand_coord();
    exp_q.push_back({zb, yb, zt, yt});
    send_frame(pack_payload(zb, yb, zt, yt), -1);
    wait_frames_done();

    // byte 2 dropped, next frame's first sync byte fills the gap
    pay = pack_payload(rand_coord(), rand_coord(), rand_coord(), rand_coord());
    acc = {pay[47:32], pay[23:0], `HAND_LINK_SYNC_BYTE};
    exp_q.push_back(unpack_payload(acc));
    send_frame(pay, 2);
    check_steady("bad stop byte");
    // no 0xff here, so this frame only realigns the parser
    send_frame(pack_payload(12'h123, 12'h456, 12'h789, 12'hABC), -1);
    wait_frames_done();
    check_steady("realign");
    zb = rand_coord();
    yb = rand_coord();
    zt = rand_coord();
    yt = rand_coord();
    exp_q.push_back({zb, yb, zt, yt});
    send_frame(pack_payload(zb, yb, zt, yt), -1);
    wait_frames_done();

    // display shows the bottom point, digits 7 and 3 zero
    word = {4'h0, cur_zb, 4'h0, cur_yb};
    for (int d = 0; d < 8; d++) begin
      n = 0;
      while (an !== ~(8'b1 << d)) begin
        if (n >= DISP_WAIT) begin
          abort_run("display anode never selected the expected digit");
        end
        @(negedge clk_65mhz);
        n++;
      end
      check_value($sformatf("display digit %0d", d), {25'd0, ~hex_glyph(word[d * 4 +: 4])}, cat);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+source
source/hand_link_pkg.sv
source/uart_rx.sv
source/hand_frame_parser.sv
source/seven_segment_controller.sv
source/hand_link_top.sv
bench/clock_gen.sv
bench/hand_link_tb.sv
